/* design/axis_shift_pkg.sv */
package axis_shift_pkg;

    // beat geometry for the full-width build
    // 64 bytes per beat, one keep bit per byte
    localparam int data_bytes_default = 64;

    // bits per byte lane
    localparam int byte_bits = 8;

    // full data bus width
    localparam int data_bits_default = data_bytes_default * byte_bits;

    // offset must hold a popcount of 0..64, so one bit more than log2(64)
    localparam int offset_bits = $clog2(data_bytes_default) + 1;

    // rotate stage numbers run 0..5 for the 64-byte build
    localparam int stage_index_bits = 3;

    // one beat of payload, byte 0 in the low bits
    typedef logic [data_bits_default-1:0] beat_data_t;

    // byte enables, bit n qualifies byte n
    typedef logic [data_bytes_default-1:0] beat_keep_t;

    // byte count or running packet offset
    // counts go up to 64; offsets stay in 0..63
    typedef logic [offset_bits-1:0] byte_offset_t;

    // selects which offset bit a stage looks at
    // stage i rotates by 2**i bytes
    typedef logic [stage_index_bits-1:0] stage_index_t;

endpackage

/* design/axis_stage_if.sv */
`timescale 1ns/1ps

// one beat as it sits between two register stages of the rotate pipeline
interface axis_stage_if
    import axis_shift_pkg::*;
();

    // payload bytes, rotated progressively along the chain
    beat_data_t   data;

    // byte enables, rotated together with the data
    beat_keep_t   keep;

    // packet byte offset of this beat, modulo beat width
    // each stage consumes one bit of it
    byte_offset_t offset;

    // beat present in this stage
    logic         valid;

    // end of packet marker
    logic         last;

    // last beat of the whole transfer, carried untouched
    logic         last_transfer;

    // register stage that produces the beat
    modport src (
        output data,
        output keep,
        output offset,
        output valid,
        output last,
        output last_transfer
    );

    // register stage that consumes the beat
    modport dst (
        input data,
        input keep,
        input offset,
        input valid,
        input last,
        input last_transfer
    );

endinterface

/* design/barrel_shifter_axis.sv */
`timescale 1ns/1ps

// AXI-Stream byte rotation pipeline
// each beat leaves rotated by its packet offset so its bytes follow on
// from the earlier beats; merging of spilled bytes is done downstream
// using offset_out
module barrel_shifter_axis
    import axis_shift_pkg::*;
#(
    parameter int data_bytes = data_bytes_default
) (
    input  logic         aclk,
    input  logic         aresetn,

    // global pipeline freeze, low holds every register
    input  logic         enable,

    // input beat
    input  beat_data_t   data_in,
    input  beat_keep_t   keep_in,
    input  logic         valid_in,
    input  logic         last_in,
    input  logic         last_transfer_flag_in,

    // rotated output beat
    output beat_data_t   data_out,
    output beat_keep_t   keep_out,
    output logic         valid_out,
    output logic         last_out,
    output logic         last_transfer_flag_out,
    output byte_offset_t offset_out
);

    // one rotate stage per offset bit
    localparam int stage_count = $clog2(data_bytes);

    // bus 0 is the input register, bus stage_count the result
    axis_stage_if stage_bus [stage_count+1] ();

    // offset for bus 0 comes from the counter
    // same edge as the input register below, so the two stay aligned
    keep_byte_counter #(
        .data_bytes (data_bytes)
    ) u_keep_byte_counter (
        .aclk    (aclk),
        .aresetn (aresetn),
        .enable  (enable),
        .keep    (keep_in),
        .valid   (valid_in),
        .last    (last_in),
        .offset  (stage_bus[0].offset)
    );

    // input register, first pipeline cycle
    // payload loaded every enabled edge, idle beats carry valid low
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            stage_bus[0].data <= '0;
            stage_bus[0].keep <= '0;
        end else if (enable) begin
            stage_bus[0].data <= data_in;
            stage_bus[0].keep <= keep_in;
        end
    end

    // input register sideband
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            stage_bus[0].valid         <= 1'b0;
            stage_bus[0].last          <= 1'b0;
            stage_bus[0].last_transfer <= 1'b0;
        end else if (enable) begin
            stage_bus[0].valid         <= valid_in;
            stage_bus[0].last          <= last_in;
            stage_bus[0].last_transfer <= last_transfer_flag_in;
        end
    end

    // rotate chain
    // stage i handles offset bit i, 2**i bytes
    for (genvar i = 0; i < stage_count; i++) begin : gen_rotate
        byte_rotate_stage #(
            .data_bytes  (data_bytes),
            .stage_index (stage_index_t'(i))
        ) u_byte_rotate_stage (
            .aclk    (aclk),
            .aresetn (aresetn),
            .enable  (enable),
            .up      (stage_bus[i].dst),
            .down    (stage_bus[i+1].src)
        );
    end

    // last stage registers are the result
    assign data_out               = stage_bus[stage_count].data;
    assign keep_out               = stage_bus[stage_count].keep;
    assign valid_out              = stage_bus[stage_count].valid;
    assign last_out               = stage_bus[stage_count].last;
    assign last_transfer_flag_out = stage_bus[stage_count].last_transfer;

    // consumer needs the offset to merge neighbouring beats
    assign offset_out             = stage_bus[stage_count].offset;

endmodule

/* design/byte_rotate_stage.sv */
`timescale 1ns/1ps

// execute side of the pipeline
// one register stage, rotates the beat left by a fixed 2**stage_index
// bytes when the matching bit of its offset is set
module byte_rotate_stage
    import axis_shift_pkg::*;
#(
    parameter int           data_bytes  = data_bytes_default,
    parameter stage_index_t stage_index = '0
) (
    input  logic aclk,
    input  logic aresetn,
    input  logic enable,
    axis_stage_if.dst up,
    axis_stage_if.src down
);

    // rotate distance of this stage
    localparam int shift_bytes = 1 << stage_index;
    localparam int shift_bits  = shift_bytes * byte_bits;

    // active part of the bus for this build
    localparam int data_bits = data_bytes * byte_bits;

    // shifter outputs before the register
    beat_data_t rot_data;
    beat_keep_t rot_keep;

    // this stage's share of the offset
    logic rot_sel;

    assign rot_sel = up.offset[stage_index];

    // left rotate moves byte n up to byte n + shift_bytes
    // top bytes wrap around into the bottom lanes
    // lanes above data_bytes stay zero
    always_comb begin
        rot_data = '0;
        rot_keep = '0;
        if (rot_sel) begin
            rot_data[data_bits-1:0] = {
                up.data[data_bits-shift_bits-1:0],
                up.data[data_bits-1:data_bits-shift_bits]
            };
            rot_keep[data_bytes-1:0] = {
                up.keep[data_bytes-shift_bytes-1:0],
                up.keep[data_bytes-1:data_bytes-shift_bytes]
            };
        end else begin
            rot_data[data_bits-1:0]  = up.data[data_bits-1:0];
            rot_keep[data_bytes-1:0] = up.keep[data_bytes-1:0];
        end
    end

    // payload register
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            down.data <= '0;
            down.keep <= '0;
        end else if (enable) begin
            down.data <= rot_data;
            down.keep <= rot_keep;
        end
    end

    // sideband copied through unchanged
    // offset still needed by the later stages and by the consumer
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            down.offset        <= '0;
            down.valid         <= 1'b0;
            down.last          <= 1'b0;
            down.last_transfer <= 1'b0;
        end else if (enable) begin
            down.offset        <= up.offset;
            down.valid         <= up.valid;
            down.last          <= up.last;
            down.last_transfer <= up.last_transfer;
        end
    end

endmodule

/* design/keep_byte_counter.sv */
`timescale 1ns/1ps

// decode side of the pipeline
// turns the keep pattern of each beat into the packet offset that
// the rotate stages use as their shift control
module keep_byte_counter
    import axis_shift_pkg::*;
#(
    parameter int data_bytes = data_bytes_default
) (
    input  logic         aclk,
    input  logic         aresetn,
    input  logic         enable,
    input  beat_keep_t   keep,
    input  logic         valid,
    input  logic         last,
    output byte_offset_t offset
);

    // modulo data_bytes is a mask, data_bytes is a power of two
    localparam byte_offset_t offset_mask = byte_offset_t'(data_bytes - 1);

    // number of kept bytes in the incoming beat
    byte_offset_t keep_count;

    // bytes of the current packet so far, modulo beat width
    byte_offset_t accum;

    // raw sum, can reach 63 + 64 and still fits in offset width
    byte_offset_t accum_sum;

    // accumulator value after this beat
    byte_offset_t accum_next;

    // beat is actually accepted this edge
    logic count_en;

    assign count_en = valid & enable;

    // popcount over the active keep lanes only
    always_comb begin
        keep_count = '0;
        for (int b = 0; b < data_bytes; b++) begin
            keep_count = keep_count + byte_offset_t'(keep[b]);
        end
    end

    // wrap to beat width
    assign accum_sum  = accum + keep_count;
    assign accum_next = accum_sum & offset_mask;

    // running accumulator
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            accum <= '0;
        end else if (count_en) begin
            // next packet starts aligned
            if (last) begin
                accum <= '0;
            end else begin
                accum <= accum_next;
            end
        end
    end

    // offset of the beat is the count before it was added
    // lines up with the input register of the top level
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            offset <= '0;
        end else if (count_en) begin
            offset <= accum;
        end
    end

endmodule

/* flist.f */
+incdir+testbench
design/axis_shift_pkg.sv
design/axis_stage_if.sv
design/keep_byte_counter.sv
design/byte_rotate_stage.sv
design/barrel_shifter_axis.sv
testbench/tb_barrel_shifter_axis.sv

/* testbench/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// one expected output beat
// in_cycle is the enabled cycle count when the beat was driven
typedef struct packed {
    beat_data_t   data;
    beat_keep_t   keep;
    byte_offset_t offset;
    logic         last;
    logic         last_transfer;
    logic [31:0]  in_cycle;
} beat_rec_t;

// reference for one accepted beat
// offset is the packet byte count before this beat, modulo beat width
// data and keep rotate left by that many bytes in one step
function automatic beat_rec_t expected_beat(
    inout byte_offset_t accum,
    input beat_data_t   data,
    input beat_keep_t   keep,
    input logic         last,
    input logic         last_transfer
);
    beat_rec_t r;
    int        kept;
    int        off;
    int        dst;
    r        = '0;
    kept     = 0;
    off      = int'(accum);
    r.offset = accum;
    r.last   = last;
    r.last_transfer = last_transfer;
    for (int n = 0; n < data_bytes_default; n++) begin
        // byte n lands in lane n + off, wrapping at the top
        dst = (n + off) % data_bytes_default;
        r.data[dst*8 +: 8] = data[n*8 +: 8];
        r.keep[dst]        = keep[n];
        if (keep[n]) begin
            kept++;
        end
    end
    // next packet restarts at lane 0
    if (last) begin
        accum = '0;
    end else begin
        accum = byte_offset_t'((off + kept) % data_bytes_default);
    end
    return r;
endfunction

`endif

/* testbench/tb_barrel_shifter_axis.sv */
`timescale 1ns/1ps

module tb_barrel_shifter_axis
    import axis_shift_pkg::*;
();

    `include "tb_ref_model.svh"

    // stimulus sizes, also used for the watchdog budget
    localparam int num_packets = 10;
    localparam int max_len     = 6;
    localparam int max_gap     = 3;
    localparam int beat_budget = 5 * num_packets * max_len;
    localparam int idle_budget = 12 + num_packets * max_len * max_gap + 5 * 16;
    localparam int cycle_budget = beat_budget + idle_budget + 7 + 100;

    logic         aclk = 1'b0;
    logic         aresetn;
    logic         enable;
    beat_data_t   data_in;
    beat_keep_t   keep_in;
    logic         valid_in;
    logic         last_in;
    logic         last_transfer_flag_in;
    beat_data_t   data_out;
    beat_keep_t   keep_out;
    logic         valid_out;
    logic         last_out;
    logic         last_transfer_flag_out;
    byte_offset_t offset_out;

    // expected beats in input order
    beat_rec_t    exp_q[$];
    byte_offset_t ref_accum;
    int           cycle_cnt;
    int           err_count;
    int           test_errs;
    int           pass_tests;
    int           fail_tests;
    string        cur_test;
    bit           check_latency;

    barrel_shifter_axis #(
        .data_bytes (64)
    ) uut (
        .aclk                   (aclk),
        .aresetn                (aresetn),
        .enable                 (enable),
        .data_in                (data_in),
        .keep_in                (keep_in),
        .valid_in               (valid_in),
        .last_in                (last_in),
        .last_transfer_flag_in  (last_transfer_flag_in),
        .data_out               (data_out),
        .keep_out               (keep_out),
        .valid_out              (valid_out),
        .last_out               (last_out),
        .last_transfer_flag_out (last_transfer_flag_out),
        .offset_out             (offset_out)
    );

    always #2 aclk = ~aclk;

    // enabled edges only, the pipeline does not move otherwise
    always @(posedge aclk) begin
        if (aresetn && enable) begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    function automatic beat_data_t random_data();
        beat_data_t d;
        for (int w = 0; w < 16; w++) begin
            d[w*32 +: 32] = $urandom;
        end
        return d;
    endfunction

    // low n lanes kept
    function automatic beat_keep_t keep_mask(input int n);
        beat_keep_t m;
        for (int i = 0; i < 64; i++) begin
            m[i] = (i < n);
        end
        return m;
    endfunction

    task automatic report_value(input string field, input logic [511:0] exp_v,
                                input logic [511:0] act_v);
        $display("** Error: test %s, %s expected %0h actual %0h", cur_test, field, exp_v, act_v);
        err_count++;
    endtask

    // a beat is taken downstream when the next edge is enabled
    // so a held beat during a stall counts once
    always @(negedge aclk) begin : compare_outputs
        beat_rec_t exp_b;
        if (aresetn && enable && valid_out) begin
            assert (exp_q.size() != 0) else begin
                $display("Error in test %s: output beat with no input beat outstanding",
                         cur_test);
                err_count++;
            end
            if (exp_q.size() != 0) begin
                exp_b = exp_q.pop_front();
                assert (data_out == exp_b.data) else
                    report_value("data_out", exp_b.data, data_out);
                assert (keep_out == exp_b.keep) else
                    report_value("keep_out", exp_b.keep, keep_out);
                assert (offset_out == exp_b.offset) else
                    report_value("offset_out", exp_b.offset, offset_out);
                assert (last_out == exp_b.last) else
                    report_value("last_out", exp_b.last, last_out);
                assert (last_transfer_flag_out == exp_b.last_transfer) else
                    report_value("last_transfer_flag_out", exp_b.last_transfer,
                                 last_transfer_flag_out);
                // 1 input register plus 6 rotate stages
                assert (!check_latency || cycle_cnt - int'(exp_b.in_cycle) == 7) else
                    report_value("latency", 7, cycle_cnt - int'(exp_b.in_cycle));
            end
        end
    end

    // valid and last must stay low while nothing is in flight
    task automatic check_quiet(input int n);
        repeat (n) begin
            @(negedge aclk);
            assert (valid_out == 1'b0 && last_out == 1'b0) else begin
                $display("Error in test %s: valid_out or last_out high with no beat sent",
                         cur_test);
                err_count++;
            end
        end
    endtask

    // holds the beat until an enabled edge takes it
    task automatic send_beat(input beat_data_t d, input beat_keep_t k, input logic last,
                             input logic lt, input bit stall);
        beat_rec_t rec;
        bit        accepted;
        accepted = 0;
        while (!accepted) begin
            @(posedge aclk);
            #1;
            enable                = stall ? ($urandom_range(0, 3) != 0) : 1'b1;
            data_in               = d;
            keep_in               = k;
            valid_in              = 1'b1;
            last_in               = last;
            last_transfer_flag_in = lt;
            if (enable) begin
                rec          = expected_beat(ref_accum, d, k, last, lt);
                rec.in_cycle = cycle_cnt;
                exp_q.push_back(rec);
                accepted     = 1;
            end
        end
    endtask

    // junk on data and keep, must not reach the counter
    task automatic idle_cycles(input int n, input bit stall);
        repeat (n) begin
            @(posedge aclk);
            #1;
            enable                = stall ? ($urandom_range(0, 3) != 0) : 1'b1;
            valid_in              = 1'b0;
            last_in               = 1'b0;
            last_transfer_flag_in = 1'b0;
            data_in               = random_data();
            keep_in               = keep_mask($urandom_range(0, 64));
        end
    endtask

    task automatic send_packet(input int len, input bit partial, input bit stall,
                               input bit gaps, input bit final_pkt);
        beat_data_t d;
        int         n;
        for (int b = 0; b < len; b++) begin
            d = random_data();
            n = partial ? $urandom_range(1, 64) : 64;
            send_beat(d, keep_mask(n), b == len - 1, final_pkt && b == len - 1, stall);
            if (gaps) begin
                idle_cycles($urandom_range(0, max_gap), stall);
            end
        end
    endtask

    task automatic run_packets(input int lmax, input bit partial, input bit stall,
                               input bit gaps);
        for (int p = 0; p < num_packets; p++) begin
            send_packet($urandom_range(1, lmax), partial, stall, gaps, p == num_packets - 1);
        end
        // empty the pipe, then watch for stray beats
        @(posedge aclk);
        #1;
        enable   = 1'b1;
        valid_in = 1'b0;
        last_in  = 1'b0;
        last_transfer_flag_in = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge aclk);
        end
        repeat (8) @(posedge aclk);
    endtask

    task automatic start_test(input string name, input bit lat);
        cur_test      = name;
        check_latency = lat;
        test_errs     = err_count;
    endtask

    task automatic finish_test();
        if (err_count == test_errs) begin
            pass_tests++;
            $display("test %s passed", cur_test);
        end else begin
            fail_tests++;
            $display("test %s failed with %0d errors", cur_test, err_count - test_errs);
        end
    endtask

    initial begin
        void'($urandom(32'hebe0));
        aresetn               = 1'b0;
        enable                = 1'b1;
        data_in               = '0;
        keep_in               = '0;
        valid_in              = 1'b0;
        last_in               = 1'b0;
        last_transfer_flag_in = 1'b0;
        ref_accum             = '0;
        cycle_cnt             = 0;
        err_count             = 0;
        pass_tests            = 0;
        fail_tests            = 0;

        // reset low across 8 rising edges
        start_test("reset_state", 1);
        check_quiet(7);
        @(posedge aclk);
        #1;
        aresetn = 1'b1;
        check_quiet(4);
        finish_test();

        start_test("full_keep", 1);
        run_packets(max_len, 0, 0, 0);
        finish_test();

        start_test("partial_keep", 1);
        run_packets(max_len, 1, 0, 0);
        finish_test();

        // short packets so boundaries come often
        start_test("packet_boundary", 1);
        run_packets(3, 1, 0, 0);
        finish_test();

        start_test("enable_stall", 0);
        run_packets(max_len, 1, 1, 0);
        finish_test();

        start_test("idle_gaps", 1);
        run_packets(max_len, 1, 0, 1);
        finish_test();

        $display("tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // five clock periods per budgeted cycle, room for stalls
    initial begin
        #(cycle_budget * 20);
        $display("watchdog expired in test %s, pipeline did not drain in time", cur_test);
        $display("Test FAILED");
        $finish;
    end

endmodule
